//--- src/core_cfg_pkg.sv
`default_nettype none

// Core-wide widths and reset values
package core_cfg_pkg;

    // Datapath word width
    localparam int XLEN = 32;

    // Instruction address width
    localparam int ADDR_W = 32;

    // Data word, used for CSR write data
    typedef logic [XLEN-1:0] xlen_t;

    // Instruction address, used for PC, mepc, mtvec and redirect target
    typedef logic [ADDR_W-1:0] addr_t;

    // Handler base out of reset
    // Low two bits are the mode field, 00 is direct
    localparam addr_t MTVEC_RESET = 32'h0000_0100;

endpackage : core_cfg_pkg

`default_nettype wire

//--- src/trap_pkg.sv
`default_nettype none

// Trap causes, interrupt ids and trap CSR addresses
package trap_pkg;

    localparam int CAUSE_W    = 32;  // Full mcause width
    localparam int CODE_W     = 5;   // Cause code field
    localparam int IRQ_ID_W   = 5;   // Up to 32 interrupt numbers
    localparam int CSR_ADDR_W = 12;  // Standard CSR address space

    // mcause value, top bit flags an interrupt
    typedef logic [CAUSE_W-1:0] cause_t;

    // Exception code from the core
    typedef logic [CODE_W-1:0] exc_code_t;

    // Interrupt line number
    typedef logic [IRQ_ID_W-1:0] irq_id_t;

    // CSR address
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // Trap CSR write addresses
    localparam csr_addr_t CSR_MIE   = 12'h304;
    localparam csr_addr_t CSR_MTVEC = 12'h305;

    // Line n reports code IRQ_CODE_BASE + n
    localparam exc_code_t IRQ_CODE_BASE = 5'd16;

    // mtvec mode field, bit 1 is reserved
    localparam logic [1:0] MTVEC_MODE_DIRECT   = 2'b00;
    localparam logic [1:0] MTVEC_MODE_VECTORED = 2'b01;

endpackage : trap_pkg

`default_nettype wire

//--- src/interrupt_controller.sv
`default_nettype none

module interrupt_controller #(
    parameter int NUM_IRQ = 8
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [NUM_IRQ-1:0]  irq_i,
    input  logic                csr_we_i,
    input  trap_pkg::csr_addr_t csr_addr_i,
    input  core_cfg_pkg::xlen_t csr_wdata_i,
    input  logic                int_ack_i,
    output logic                interrupt_o,
    output trap_pkg::irq_id_t   irq_id_o
);

    logic [NUM_IRQ-1:0] pending_q;   // Latched interrupt lines
    logic [NUM_IRQ-1:0] mie_q;       // Per-line enables
    logic [NUM_IRQ-1:0] masked;      // Pending and enabled
    logic [NUM_IRQ-1:0] ack_clr;     // One-hot clear of the acked line
    logic               any_masked;
    trap_pkg::irq_id_t  sel_id;      // Winner of the priority search
    logic               mie_we;
    logic               req_q;       // Request toward the trap manager
    trap_pkg::irq_id_t  id_q;        // Id presented with the request

    // Ids must fit irq_id_t and codes must stay below 32
    if (NUM_IRQ < 1 || NUM_IRQ > 16) begin : g_num_irq_check
        $error("interrupt_controller: NUM_IRQ out of range 1..16");
    end

    assign mie_we = csr_we_i && (csr_addr_i == trap_pkg::CSR_MIE);
    assign masked = pending_q & mie_q;

    // Lowest line number wins
    always_comb begin
        any_masked = 1'b0;
        sel_id     = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (masked[i]) begin
                any_masked = 1'b1;
                sel_id     = trap_pkg::irq_id_t'(i);
            end
        end
    end

    // Only the line that was presented gets cleared
    always_comb begin
        for (int i = 0; i < NUM_IRQ; i++) begin
            ack_clr[i] = int_ack_i && (id_q == trap_pkg::irq_id_t'(i));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
            mie_q     <= '0;   // Everything masked out of reset
            req_q     <= 1'b0;
        end else begin
            // A line still high re-arms its own pending bit
            pending_q <= (pending_q & ~ack_clr) | irq_i;

            if (mie_we) begin
                mie_q <= csr_wdata_i[NUM_IRQ-1:0];  // Enables in the low bits
            end

            // Hold until the one-cycle ack, then rearbitrate
            if (int_ack_i) begin
                req_q <= 1'b0;
            end else if (!req_q) begin
                req_q <= any_masked;
            end
        end
    end

    // Id loads together with the request and stays frozen while it is up
    always_ff @(posedge clk_i) begin
        if (!req_q) begin
            id_q <= sel_id;
        end
    end

    assign interrupt_o = req_q;
    assign irq_id_o    = id_q;

endmodule : interrupt_controller

`default_nettype wire

//--- src/trap_manager.sv
`default_nettype none

module trap_manager (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic interrupt_i,
    input  logic exception_i,
    input  logic core_sleep_i,
    output logic flush_o,
    output logic stall_o,
    output logic int_ack_o,
    output logic trap_o
);

    typedef enum logic [1:0] {
        IDLE,
        ACK_CYCLE,     // Handler fetch under way, ack the controller
        CLEAR_CYCLE,   // Spare, never entered
        WAIT_WAKE_UP   // Core asleep until an interrupt
    } trap_state_t;

    trap_state_t state_q;
    trap_state_t state_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Mealy outputs, IDLE reacts in the same cycle
    always_comb begin
        state_d   = state_q;
        flush_o   = 1'b0;
        stall_o   = 1'b0;
        int_ack_o = 1'b0;
        trap_o    = 1'b0;

        case (state_q)
            IDLE: begin
                trap_o = interrupt_i | exception_i;

                if (interrupt_i) begin
                    // Interrupt beats exception
                    flush_o = 1'b1;
                    state_d = ACK_CYCLE;
                end else if (exception_i) begin
                    if (core_sleep_i) begin
                        stall_o = 1'b1;   // Freeze instead of flushing
                        state_d = WAIT_WAKE_UP;
                    end else begin
                        flush_o = 1'b1;   // Straight to the handler
                    end
                end
            end

            ACK_CYCLE: begin
                int_ack_o = 1'b1;         // One cycle after the flush
                state_d   = IDLE;
            end

            WAIT_WAKE_UP: begin
                stall_o = 1'b1;
                // Wake up now, take the interrupt from IDLE next cycle
                if (interrupt_i) begin
                    state_d = IDLE;
                end
            end

            CLEAR_CYCLE: begin
                state_d = IDLE;           // Recover if ever reached
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule : trap_manager

`default_nettype wire

//--- src/trap_csr_unit.sv
`default_nettype none

module trap_csr_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                interrupt_i,
    input  trap_pkg::irq_id_t   irq_id_i,
    input  trap_pkg::exc_code_t exc_code_i,
    input  core_cfg_pkg::addr_t pc_i,
    input  logic                csr_we_i,
    input  trap_pkg::csr_addr_t csr_addr_i,
    input  core_cfg_pkg::xlen_t csr_wdata_i,
    output logic                redirect_valid_o,
    output core_cfg_pkg::addr_t redirect_pc_o,
    output core_cfg_pkg::addr_t mepc_o,
    output trap_pkg::cause_t    mcause_o
);

    localparam int XLEN = core_cfg_pkg::XLEN;

    core_cfg_pkg::addr_t mtvec_q;
    core_cfg_pkg::addr_t mepc_q;
    trap_pkg::cause_t    mcause_q;

    logic                mtvec_we;
    logic [1:0]          mtvec_mode;
    core_cfg_pkg::addr_t mtvec_base;   // Mode bits cleared
    trap_pkg::exc_code_t cause_code;   // Code field of the new cause
    trap_pkg::cause_t    cause_d;
    core_cfg_pkg::addr_t vector_pc;    // Base plus 4 * code

    assign mtvec_we   = csr_we_i && (csr_addr_i == trap_pkg::CSR_MTVEC);
    assign mtvec_mode = mtvec_q[1:0];
    assign mtvec_base = {mtvec_q[core_cfg_pkg::ADDR_W-1:2], 2'b00};

    // Interrupt codes sit above the exception codes
    assign cause_code = interrupt_i ? (trap_pkg::IRQ_CODE_BASE + irq_id_i) : exc_code_i;

    assign cause_d = {interrupt_i,
                      {(trap_pkg::CAUSE_W - 1 - trap_pkg::CODE_W){1'b0}},
                      cause_code};

    assign vector_pc = mtvec_base + core_cfg_pkg::addr_t'({cause_code, 2'b00});

    // Handler target, only interrupts are vectored
    always_comb begin
        case (mtvec_mode)
            trap_pkg::MTVEC_MODE_DIRECT:   redirect_pc_o = mtvec_base;
            trap_pkg::MTVEC_MODE_VECTORED: redirect_pc_o = interrupt_i ? vector_pc : mtvec_base;
            default:                       redirect_pc_o = mtvec_base;
        endcase
    end

    assign redirect_valid_o = flush_i;   // Same cycle as the flush

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtvec_q <= core_cfg_pkg::MTVEC_RESET;
        end else if (mtvec_we) begin
            // Bit 0 picks vectored mode, bit 1 reads as zero
            mtvec_q <= {csr_wdata_i[XLEN-1:2], 1'b0, csr_wdata_i[0]};
        end
    end

    // Trap record, captured on every flush cycle
    always_ff @(posedge clk_i) begin
        if (flush_i) begin
            mepc_q   <= pc_i;      // Instruction that was cut off
            mcause_q <= cause_d;
        end
    end

    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

endmodule : trap_csr_unit

`default_nettype wire

//--- src/trap_control_top.sv
`default_nettype none

module trap_control_top #(
    parameter int NUM_IRQ = 8
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Event sources
    input  logic [NUM_IRQ-1:0]  irq_i,
    input  logic                exception_i,
    input  trap_pkg::exc_code_t exc_code_i,
    input  logic                core_sleep_i,
    input  core_cfg_pkg::addr_t pc_i,

    // CSR write port, shared by controller and CSR unit
    input  logic                csr_we_i,
    input  trap_pkg::csr_addr_t csr_addr_i,
    input  core_cfg_pkg::xlen_t csr_wdata_i,

    // Pipeline control
    output logic                flush_o,
    output logic                stall_o,
    output logic                trap_o,
    output logic                int_ack_o,

    // Fetch redirect and trap record
    output logic                redirect_valid_o,
    output core_cfg_pkg::addr_t redirect_pc_o,
    output core_cfg_pkg::addr_t mepc_o,
    output trap_pkg::cause_t    mcause_o
);

    logic              interrupt_req;  // Held until int_ack_o
    trap_pkg::irq_id_t irq_id;         // Stable while interrupt_req is up

    interrupt_controller #(
        .NUM_IRQ (NUM_IRQ)
    ) u_irq_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .irq_i       (irq_i),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .int_ack_i   (int_ack_o),
        .interrupt_o (interrupt_req),
        .irq_id_o    (irq_id)
    );

    trap_manager u_trap_mgr (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .interrupt_i  (interrupt_req),
        .exception_i  (exception_i),
        .core_sleep_i (core_sleep_i),
        .flush_o      (flush_o),
        .stall_o      (stall_o),
        .int_ack_o    (int_ack_o),
        .trap_o       (trap_o)
    );

    trap_csr_unit u_trap_csr (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_o),          // Record on every flush
        .interrupt_i      (interrupt_req),
        .irq_id_i         (irq_id),
        .exc_code_i       (exc_code_i),
        .pc_i             (pc_i),
        .csr_we_i         (csr_we_i),
        .csr_addr_i       (csr_addr_i),
        .csr_wdata_i      (csr_wdata_i),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .mepc_o           (mepc_o),
        .mcause_o         (mcause_o)
    );

endmodule : trap_control_top

`default_nettype wire

//--- bench/trap_control_asserts.sv
`default_nettype none

// Protocol checks on the trap manager boundary
module trap_control_asserts (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic interrupt_i,   // Request from the controller
    input  logic flush_i,
    input  logic stall_i,
    input  logic int_ack_i,
    input  logic trap_i
);

    // Ack only right after an interrupt flush
    a_ack_after_irq_flush: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        int_ack_i |-> $past(flush_i && interrupt_i)
    ) else $error("int_ack_o without an interrupt flush in the cycle before");

    // Every interrupt flush gets its ack
    a_irq_flush_then_ack: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (flush_i && interrupt_i) |=> int_ack_i
    ) else $error("interrupt flush not followed by int_ack_o");

    a_no_flush_with_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(flush_i && stall_i)
    ) else $error("flush_o and stall_o high together");

    // Request held until acknowledged
    a_req_held: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (interrupt_i && !int_ack_i) |=> interrupt_i
    ) else $error("interrupt request dropped before int_ack_o");

    // Second reset cycle onward, state is known
    a_quiet_in_reset: assert property (
        @(posedge clk_i)
        (!rst_n_i ##1 !rst_n_i) |-> !(flush_i || stall_i || int_ack_i || trap_i)
    ) else $error("trap manager output high during reset");

endmodule : trap_control_asserts

bind trap_manager trap_control_asserts u_trap_asserts (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .interrupt_i (interrupt_i),
    .flush_i     (flush_o),
    .stall_i     (stall_o),
    .int_ack_i   (int_ack_o),
    .trap_i      (trap_o)
);

`default_nettype wire

//--- bench/trap_control_tb.sv
`default_nettype none

module trap_control_tb;

    localparam int NUM_IRQ    = 8;
    localparam int WAIT_LIMIT = 32;   // Cycles before a wait gives up

    logic                clk_i;
    logic                rst_n_i;
    logic [NUM_IRQ-1:0]  irq_i;
    logic                exception_i;
    trap_pkg::exc_code_t exc_code_i;
    logic                core_sleep_i;
    core_cfg_pkg::addr_t pc_i;
    logic                csr_we_i;
    trap_pkg::csr_addr_t csr_addr_i;
    core_cfg_pkg::xlen_t csr_wdata_i;

    logic                flush_o;
    logic                stall_o;
    logic                trap_o;
    logic                int_ack_o;
    logic                redirect_valid_o;
    core_cfg_pkg::addr_t redirect_pc_o;
    core_cfg_pkg::addr_t mepc_o;
    trap_pkg::cause_t    mcause_o;

    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          tests;

    trap_control_top #(
        .NUM_IRQ (NUM_IRQ)
    ) u_dut (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .irq_i            (irq_i),
        .exception_i      (exception_i),
        .exc_code_i       (exc_code_i),
        .core_sleep_i     (core_sleep_i),
        .pc_i             (pc_i),
        .csr_we_i         (csr_we_i),
        .csr_addr_i       (csr_addr_i),
        .csr_wdata_i      (csr_wdata_i),
        .flush_o          (flush_o),
        .stall_o          (stall_o),
        .trap_o           (trap_o),
        .int_ack_o        (int_ack_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .mepc_o           (mepc_o),
        .mcause_o         (mcause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Low LCG bits cycle fast so the halves are swapped
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got=%h exp=%h at %0t", name, got, exp, $time);
        end
    endtask

    // Drive point sits 1 unit past the rising edge
    task automatic to_drive_point();
        @(posedge clk_i);
        #1;
    endtask

    task automatic apply_reset();
        rst_n_i      = 1'b0;
        irq_i        = '0;
        exception_i  = 1'b0;
        exc_code_i   = '0;
        core_sleep_i = 1'b0;
        pc_i         = '0;
        csr_we_i     = 1'b0;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
    endtask

    task automatic csr_write(input trap_pkg::csr_addr_t addr, input core_cfg_pkg::xlen_t data);
        csr_we_i    = 1'b1;
        csr_addr_i  = addr;
        csr_wdata_i = data;
        to_drive_point();
        csr_we_i = 1'b0;
    endtask

    // One-cycle pulse so each line is latched once
    task automatic raise_irq(input logic [NUM_IRQ-1:0] lines);
        irq_i = lines;
        to_drive_point();
        irq_i = '0;
    endtask

    // Counts sample points until flush and ends at one
    task automatic wait_flush(output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
            seen = flush_o;
        end
        if (!seen) begin
            errors++;
            $display("Timeout: no flush within %0d cycles at %0t", WAIT_LIMIT, $time);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            checks++;
            if (flush_o) begin
                errors++;
                $display("Unexpected flush while no interrupt should be taken at %0t", $time);
            end
        end
        to_drive_point();
    endtask

    // Flush cycle then ack cycle with the trap record
    task automatic service_irq(input int line, input core_cfg_pkg::addr_t exp_redirect,
                               output int cycles);
        bit          seen;
        logic [31:0] exp_cause;
        exp_cause = 32'h8000_0000 | 32'(16 + line);   // Interrupt codes start at 16
        wait_flush(cycles, seen);
        if (seen) begin
            expect_eq("trap_o", trap_o, 1);
            expect_eq("redirect_valid_o", redirect_valid_o, 1);
            expect_eq("redirect_pc_o", redirect_pc_o, exp_redirect);
            expect_eq("stall_o", stall_o, 0);
            expect_eq("int_ack_o", int_ack_o, 0);
            to_drive_point();
            @(negedge clk_i);
            expect_eq("int_ack_o", int_ack_o, 1);
            expect_eq("flush_o", flush_o, 0);
            expect_eq("mcause_o", mcause_o, exp_cause);
            expect_eq("mepc_o", mepc_o, pc_i);
        end
        to_drive_point();
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_values();
        int err0;
        err0 = errors;
        apply_reset();
        @(negedge clk_i);
        expect_eq("flush_o", flush_o, 0);
        expect_eq("stall_o", stall_o, 0);
        expect_eq("trap_o", trap_o, 0);
        expect_eq("int_ack_o", int_ack_o, 0);
        expect_eq("redirect_valid_o", redirect_valid_o, 0);
        expect_eq("interrupt_req", u_dut.interrupt_req, 0);
        expect_eq("redirect_pc_o", redirect_pc_o, core_cfg_pkg::MTVEC_RESET);  // mtvec base
        to_drive_point();
        // All enables clear out of reset, so no line is taken
        raise_irq('1);
        expect_quiet(8);
        end_test("reset_values", err0);
    endtask

    task automatic test_exception_entry();
        int                  err0;
        core_cfg_pkg::addr_t pc;
        trap_pkg::exc_code_t code;
        err0 = errors;
        for (int k = 0; k < 4; k++) begin
            pc   = next_rand() & 32'hFFFF_FFFC;
            code = 5'(next_rand() % 16);   // Synchronous exception codes
            exception_i = 1'b1;
            exc_code_i  = code;
            pc_i        = pc;
            @(negedge clk_i);
            expect_eq("flush_o", flush_o, 1);           // Same cycle
            expect_eq("trap_o", trap_o, 1);
            expect_eq("redirect_valid_o", redirect_valid_o, 1);
            expect_eq("redirect_pc_o", redirect_pc_o, core_cfg_pkg::MTVEC_RESET);
            expect_eq("int_ack_o", int_ack_o, 0);
            to_drive_point();
            exception_i = 1'b0;
            @(negedge clk_i);
            expect_eq("mepc_o", mepc_o, pc);
            expect_eq("mcause_o", mcause_o, 32'(code));  // Flag bit clear
            expect_eq("flush_o", flush_o, 0);
            to_drive_point();
        end
        end_test("exception_entry", err0);
    endtask

    task automatic test_interrupt_entry();
        int                  err0;
        int                  line;
        int                  cycles;
        core_cfg_pkg::addr_t base;
        err0 = errors;
        apply_reset();
        csr_write(trap_pkg::CSR_MIE, 32'h0000_00FF);
        pc_i = next_rand() & 32'hFFFF_FFFC;
        line = next_rand() % NUM_IRQ;
        raise_irq(NUM_IRQ'(1) << line);
        service_irq(line, core_cfg_pkg::MTVEC_RESET, cycles);
        expect_eq("flush latency", cycles, 2);
        // Vectored mode with bit 1 written high, which must read as zero
        base = next_rand() & 32'h0FFF_FF00;
        csr_write(trap_pkg::CSR_MTVEC, base | 32'h3);
        line = next_rand() % NUM_IRQ;
        raise_irq(NUM_IRQ'(1) << line);
        service_irq(line, base + 32'(4 * (16 + line)), cycles);
        expect_eq("flush latency", cycles, 2);
        end_test("interrupt_entry", err0);
    endtask

    task automatic test_mask_priority();
        int                 err0;
        int                 cycles;
        logic [NUM_IRQ-1:0] pattern;
        err0 = errors;
        apply_reset();
        csr_write(trap_pkg::CSR_MIE, 32'h0000_007F);   // Line 7 stays masked
        pc_i = next_rand() & 32'hFFFF_FFFC;
        raise_irq(8'h80);
        expect_quiet(10);
        pattern = 8'(next_rand()) & 8'h7F;
        if (pattern == '0) begin
            pattern = 8'h29;
        end
        raise_irq(pattern | 8'h80);
        for (int i = 0; i < NUM_IRQ - 1; i++) begin
            if (pattern[i]) begin
                service_irq(i, core_cfg_pkg::MTVEC_RESET, cycles);   // Ascending order
            end
        end
        expect_quiet(10);   // Each line once and line 7 never
        end_test("mask_priority", err0);
    endtask

    task automatic test_irq_over_exception();
        int                  err0;
        int                  line;
        trap_pkg::exc_code_t code;
        err0 = errors;
        apply_reset();
        csr_write(trap_pkg::CSR_MIE, 32'h0000_00FF);
        pc_i = next_rand() & 32'hFFFF_FFFC;
        line = next_rand() % NUM_IRQ;
        code = 5'(next_rand() % 16);
        raise_irq(NUM_IRQ'(1) << line);
        to_drive_point();   // Request up from here
        exception_i = 1'b1;
        exc_code_i  = code;
        @(negedge clk_i);
        expect_eq("flush_o", flush_o, 1);
        expect_eq("trap_o", trap_o, 1);
        to_drive_point();
        exception_i = 1'b0;
        @(negedge clk_i);
        expect_eq("int_ack_o", int_ack_o, 1);
        expect_eq("mcause_o", mcause_o, 32'h8000_0000 | 32'(16 + line));
        expect_eq("mepc_o", mepc_o, pc_i);
        to_drive_point();
        end_test("irq_over_exception", err0);
    endtask

    task automatic test_sleep_wake();
        int err0;
        int line;
        int cycles;
        err0 = errors;
        apply_reset();
        csr_write(trap_pkg::CSR_MIE, 32'h0000_00FF);
        pc_i = next_rand() & 32'hFFFF_FFFC;
        line = next_rand() % NUM_IRQ;
        exception_i  = 1'b1;
        core_sleep_i = 1'b1;   // WFI style request
        exc_code_i   = 5'd2;
        @(negedge clk_i);
        expect_eq("stall_o", stall_o, 1);
        expect_eq("flush_o", flush_o, 0);
        expect_eq("trap_o", trap_o, 1);
        to_drive_point();
        exception_i  = 1'b0;
        core_sleep_i = 1'b0;
        repeat (5) begin
            @(negedge clk_i);
            expect_eq("stall_o", stall_o, 1);
            expect_eq("flush_o", flush_o, 0);
        end
        to_drive_point();
        raise_irq(NUM_IRQ'(1) << line);
        service_irq(line, core_cfg_pkg::MTVEC_RESET, cycles);
        expect_eq("wake flush latency", cycles, 3);   // One extra cycle to leave sleep
        end_test("sleep_wake", err0);
    endtask

    initial begin
        lcg_state = 32'd61;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        test_reset_values();
        test_exception_entry();
        test_interrupt_entry();
        test_mask_priority();
        test_irq_over_exception();
        test_sleep_wake();
        $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : trap_control_tb

`default_nettype wire

//--- files.f
src/core_cfg_pkg.sv
src/trap_pkg.sv
src/interrupt_controller.sv
src/trap_manager.sv
src/trap_csr_unit.sv
src/trap_control_top.sv
bench/trap_control_asserts.sv
bench/trap_control_tb.sv
